// ==== hw/vldst_cfg_pkg.sv ====
/*
 * Cluster configuration package for the global load-store unit.
 * Holds the cluster geometry, the vector element width encoding
 * and the metadata that describes the current vector request.
 */
package vldst_cfg_pkg;

  // Cluster geometry
  localparam int unsigned NrClusters       = 4;
  localparam int unsigned ClusterDataWidth = 64;

  // Vector length in elements
  localparam int unsigned VlWidth = 16;

  typedef logic [VlWidth-1:0] vl_t;

  // Element width as log2 of its size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Describes one unit-stride vector request
  typedef struct packed {
    vl_t  vl;
    vew_e vew;
  } ldst_meta_t;

endpackage

// ==== hw/vldst_axi_pkg.sv ====
/*
 * AXI package for the global load-store unit.
 * Channel structs for the wide system port and the narrow cluster ports,
 * the page-aware address union and the burst constants.
 */
package vldst_axi_pkg;

  // System bus geometry
  localparam int unsigned AxiDataWidth =
    vldst_cfg_pkg::NrClusters * vldst_cfg_pkg::ClusterDataWidth;
  localparam int unsigned AxiAddrWidth   = 32;
  localparam int unsigned AxiIdWidth     = 4;
  localparam int unsigned AxiSize        = $clog2(AxiDataWidth / 8);

  // A burst may neither leave a 4 KiB page nor exceed 256 beats
  localparam int unsigned PageOffsetBits = 12;
  localparam int unsigned MaxBurstBeats  = 256;

  localparam logic [1:0] BurstIncr       = 2'b01;
  localparam logic [3:0] CacheModifiable = 4'b0010;

  typedef logic [AxiAddrWidth-1:0] addr_t;

  typedef struct packed {
    logic [AxiAddrWidth-PageOffsetBits-1:0] page;
    logic [PageOffsetBits-1:0]              offset;
  } page_addr_t;

  // One address read flat or split into page and offset
  typedef union packed {
    addr_t      flat;
    page_addr_t pg;
  } axi_addr_u;

  // Shared by AR and AW
  typedef struct packed {
    axi_addr_u             addr;
    logic [AxiIdWidth-1:0] id;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [3:0]            cache;
  } axi_ax_t;

  typedef struct packed {
    logic [vldst_cfg_pkg::ClusterDataWidth-1:0]   data;
    logic [vldst_cfg_pkg::ClusterDataWidth/8-1:0] strb;
    logic                                         last;
  } cl_w_t;

  typedef struct packed {
    logic [AxiDataWidth-1:0]   data;
    logic [AxiDataWidth/8-1:0] strb;
    logic                      last;
  } sys_w_t;

  typedef struct packed {
    logic [vldst_cfg_pkg::ClusterDataWidth-1:0] data;
    logic [AxiIdWidth-1:0]                      id;
    logic [1:0]                                 resp;
    logic                                       last;
  } cl_r_t;

  typedef struct packed {
    logic [AxiDataWidth-1:0] data;
    logic [AxiIdWidth-1:0]   id;
    logic [1:0]              resp;
    logic                    last;
  } sys_r_t;

  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    logic [1:0]            resp;
  } axi_b_t;

endpackage

// ==== hw/ldst_burst_calc.sv ====
/*
 * Burst calculator. From the current address and the remaining vector
 * length it derives one bus-aligned burst that stays inside a 4 KiB page
 * and within 256 beats, plus the address where the next burst starts.
 */
`timescale 1ns/1ns

module ldst_burst_calc (
  input  vldst_axi_pkg::axi_addr_u cur_addr_i,
  input  vldst_cfg_pkg::vl_t       rem_vl_i,
  input  vldst_cfg_pkg::vew_e      vew_i,
  output vldst_axi_pkg::axi_ax_t   burst_o,
  output vldst_axi_pkg::axi_addr_u next_addr_o,
  output logic                     done_o
);

  vldst_axi_pkg::axi_addr_u start_addr;
  vldst_axi_pkg::axi_addr_u last_beat;
  vldst_axi_pkg::addr_t     span;
  vldst_axi_pkg::addr_t     last_byte;
  vldst_axi_pkg::addr_t     req_beats;
  vldst_axi_pkg::addr_t     page_beats;
  vldst_axi_pkg::addr_t     beats;
  vldst_axi_pkg::addr_t     covered;

  always_comb begin
    // Align down to the system bus width
    start_addr.flat = {cur_addr_i.flat[vldst_axi_pkg::AxiAddrWidth-1:vldst_axi_pkg::AxiSize],
                       {vldst_axi_pkg::AxiSize{1'b0}}};

    // Last byte of the request and the beat that holds it
    span      = vldst_axi_pkg::addr_t'(rem_vl_i) << vew_i;
    last_byte = cur_addr_i.flat + span - 1;
    last_beat.flat = {last_byte[vldst_axi_pkg::AxiAddrWidth-1:vldst_axi_pkg::AxiSize],
                      {vldst_axi_pkg::AxiSize{1'b0}}};

    req_beats  = ((last_beat.flat - start_addr.flat) >> vldst_axi_pkg::AxiSize) + 1;
    page_beats = ((vldst_axi_pkg::addr_t'(1) << vldst_axi_pkg::PageOffsetBits) -
                  vldst_axi_pkg::addr_t'(start_addr.pg.offset)) >> vldst_axi_pkg::AxiSize;

    // Stop at the page end when the request runs into the next page
    if (last_beat.pg.page != start_addr.pg.page) begin
      beats = page_beats;
    end else begin
      beats = req_beats;
    end
    if (beats > vldst_axi_pkg::MaxBurstBeats) begin
      beats = vldst_axi_pkg::MaxBurstBeats;
    end

    next_addr_o.flat = start_addr.flat + (beats << vldst_axi_pkg::AxiSize);

    // Elements covered from the unaligned start up to the next burst
    covered = (next_addr_o.flat - cur_addr_i.flat) >> vew_i;
    done_o  = vldst_axi_pkg::addr_t'(rem_vl_i) <= covered;

    burst_o      = '0;
    burst_o.addr = start_addr;
    burst_o.len  = beats[7:0] - 8'd1;
  end

endmodule

// ==== hw/ldst_burst_splitter.sv ====
/*
 * Burst splitter. Accepts one unit-stride vector request and issues
 * its system bursts, one per address handshake, until the request
 * is fully covered.
 */
`timescale 1ns/1ns

module ldst_burst_splitter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_valid_i,
  input  vldst_axi_pkg::axi_ax_t     req_i,
  input  vldst_cfg_pkg::ldst_meta_t  meta_i,
  output logic                       req_ready_o,
  output vldst_axi_pkg::axi_ax_t     ax_o,
  output logic                       ax_valid_o,
  input  logic                       ax_ready_i
);

  logic                                   busy_q;
  vldst_axi_pkg::axi_addr_u               addr_q;
  logic [vldst_axi_pkg::AxiIdWidth-1:0]   id_q;
  vldst_cfg_pkg::vl_t                     rem_vl_q;
  vldst_cfg_pkg::vew_e                    vew_q;

  vldst_axi_pkg::axi_ax_t   calc_burst;
  vldst_axi_pkg::axi_addr_u next_addr;
  logic                     calc_done;
  vldst_cfg_pkg::vl_t       elem_adv;
  logic                     req_fire;
  logic                     ax_fire;

  ldst_burst_calc u_calc (
    .cur_addr_i  (addr_q),
    .rem_vl_i    (rem_vl_q),
    .vew_i       (vew_q),
    .burst_o     (calc_burst),
    .next_addr_o (next_addr),
    .done_o      (calc_done)
  );

  assign req_ready_o = ~busy_q;
  assign ax_valid_o  = busy_q;
  assign req_fire    = req_valid_i & req_ready_o;
  assign ax_fire     = ax_valid_o & ax_ready_i;

  // Elements consumed by the burst on the bus
  assign elem_adv = vldst_cfg_pkg::vl_t'((next_addr.flat - addr_q.flat) >> vew_q);

  always_comb begin
    ax_o       = calc_burst;
    ax_o.id    = id_q;
    ax_o.size  = 3'(vldst_axi_pkg::AxiSize);
    ax_o.burst = vldst_axi_pkg::BurstIncr;
    ax_o.cache = vldst_axi_pkg::CacheModifiable;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (req_fire) begin
      busy_q <= 1'b1;
    end else if (ax_fire && calc_done) begin
      busy_q <= 1'b0;
    end
  end

  // Request state, loaded on accept and advanced per burst
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      addr_q   <= req_i.addr;
      id_q     <= req_i.id;
      rem_vl_q <= meta_i.vl;
      vew_q    <= meta_i.vew;
    end else if (ax_fire && !calc_done) begin
      addr_q   <= next_addr;
      rem_vl_q <= rem_vl_q - elem_adv;
    end
  end

endmodule

// ==== hw/ldst_read_fanout.sv ====
/*
 * Read data fan-out. Buffers one wide system read beat and hands
 * slice i to cluster i, releasing the beat when all clusters take it.
 */
`timescale 1ns/1ns

module ldst_read_fanout (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  vldst_axi_pkg::sys_r_t                           sys_r_i,
  input  logic                                            sys_r_valid_i,
  output logic                                            sys_r_ready_o,
  output vldst_axi_pkg::cl_r_t [vldst_cfg_pkg::NrClusters-1:0] cl_r_o,
  output logic                                            cl_r_valid_o,
  input  logic [vldst_cfg_pkg::NrClusters-1:0]            cl_r_ready_i
);

  logic                  valid_q;
  vldst_axi_pkg::sys_r_t beat_q;
  logic                  all_ready;
  logic                  sys_fire;

  assign all_ready     = &cl_r_ready_i;
  // Empty, or emptied by the clusters on this edge
  assign sys_r_ready_o = ~valid_q | all_ready;
  assign sys_fire      = sys_r_valid_i & sys_r_ready_o;
  assign cl_r_valid_o  = valid_q;

  always_comb begin
    for (int i = 0; i < vldst_cfg_pkg::NrClusters; i++) begin
      cl_r_o[i].data = beat_q.data[i*vldst_cfg_pkg::ClusterDataWidth +:
                                   vldst_cfg_pkg::ClusterDataWidth];
      cl_r_o[i].id   = beat_q.id;
      cl_r_o[i].resp = beat_q.resp;
      cl_r_o[i].last = beat_q.last;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (sys_fire) begin
      valid_q <= 1'b1;
    end else if (all_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sys_fire) begin
      beat_q <= sys_r_i;
    end
  end

endmodule

// ==== hw/ldst_write_gather.sv ====
/*
 * Write data gather. Collects one narrow write beat from every cluster
 * and holds the merged wide beat until the system W channel takes it.
 */
`timescale 1ns/1ns

module ldst_write_gather (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  vldst_axi_pkg::cl_w_t [vldst_cfg_pkg::NrClusters-1:0] cl_w_i,
  input  logic [vldst_cfg_pkg::NrClusters-1:0]            cl_w_valid_i,
  output logic                                            cl_w_ready_o,
  output vldst_axi_pkg::sys_w_t                           sys_w_o,
  output logic                                            sys_w_valid_o,
  input  logic                                            sys_w_ready_i
);

  logic                  valid_q;
  vldst_axi_pkg::sys_w_t beat_q;
  vldst_axi_pkg::sys_w_t merged;
  logic                  capture;

  // Take the beats only when every cluster offers one
  assign cl_w_ready_o  = ~valid_q & (&cl_w_valid_i);
  assign capture       = cl_w_ready_o;
  assign sys_w_valid_o = valid_q;
  assign sys_w_o       = beat_q;

  always_comb begin
    merged = '0;
    for (int i = 0; i < vldst_cfg_pkg::NrClusters; i++) begin
      merged.data[i*vldst_cfg_pkg::ClusterDataWidth +: vldst_cfg_pkg::ClusterDataWidth] =
        cl_w_i[i].data;
      merged.strb[i*vldst_cfg_pkg::ClusterDataWidth/8 +: vldst_cfg_pkg::ClusterDataWidth/8] =
        cl_w_i[i].strb;
    end
    // Only cluster 0 signals the end of the burst
    merged.last = cl_w_i[0].last;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;
    end else if (sys_w_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      beat_q <= merged;
    end
  end

endmodule

// ==== hw/global_ldst.sv ====
/*
 * Global load-store unit. Splits cluster 0 unit-stride requests into
 * system bursts, fans wide read data out to the clusters, gathers
 * their write data into wide beats and broadcasts write responses.
 */
`timescale 1ns/1ns

module global_ldst (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  vldst_cfg_pkg::ldst_meta_t                         meta_i,

  // Cluster side
  input  vldst_axi_pkg::axi_ax_t [vldst_cfg_pkg::NrClusters-1:0] cl_ar_i,
  input  logic [vldst_cfg_pkg::NrClusters-1:0]              cl_ar_valid_i,
  output logic [vldst_cfg_pkg::NrClusters-1:0]              cl_ar_ready_o,
  input  vldst_axi_pkg::axi_ax_t [vldst_cfg_pkg::NrClusters-1:0] cl_aw_i,
  input  logic [vldst_cfg_pkg::NrClusters-1:0]              cl_aw_valid_i,
  output logic [vldst_cfg_pkg::NrClusters-1:0]              cl_aw_ready_o,
  input  vldst_axi_pkg::cl_w_t [vldst_cfg_pkg::NrClusters-1:0]   cl_w_i,
  input  logic [vldst_cfg_pkg::NrClusters-1:0]              cl_w_valid_i,
  output logic [vldst_cfg_pkg::NrClusters-1:0]              cl_w_ready_o,
  output vldst_axi_pkg::cl_r_t [vldst_cfg_pkg::NrClusters-1:0]   cl_r_o,
  output logic [vldst_cfg_pkg::NrClusters-1:0]              cl_r_valid_o,
  input  logic [vldst_cfg_pkg::NrClusters-1:0]              cl_r_ready_i,
  output vldst_axi_pkg::axi_b_t [vldst_cfg_pkg::NrClusters-1:0]  cl_b_o,
  output logic [vldst_cfg_pkg::NrClusters-1:0]              cl_b_valid_o,
  input  logic [vldst_cfg_pkg::NrClusters-1:0]              cl_b_ready_i,

  // System side
  output vldst_axi_pkg::axi_ax_t                            sys_ar_o,
  output logic                                              sys_ar_valid_o,
  input  logic                                              sys_ar_ready_i,
  output vldst_axi_pkg::axi_ax_t                            sys_aw_o,
  output logic                                              sys_aw_valid_o,
  input  logic                                              sys_aw_ready_i,
  output vldst_axi_pkg::sys_w_t                             sys_w_o,
  output logic                                              sys_w_valid_o,
  input  logic                                              sys_w_ready_i,
  input  vldst_axi_pkg::sys_r_t                             sys_r_i,
  input  logic                                              sys_r_valid_i,
  output logic                                              sys_r_ready_o,
  input  vldst_axi_pkg::axi_b_t                             sys_b_i,
  input  logic                                              sys_b_valid_i,
  output logic                                              sys_b_ready_o
);

  logic ar_req_ready;
  logic aw_req_ready;
  logic w_ready;
  logic r_valid;

  ldst_burst_splitter u_ar_split (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (cl_ar_valid_i[0]),
    .req_i       (cl_ar_i[0]),
    .meta_i      (meta_i),
    .req_ready_o (ar_req_ready),
    .ax_o        (sys_ar_o),
    .ax_valid_o  (sys_ar_valid_o),
    .ax_ready_i  (sys_ar_ready_i)
  );

  ldst_burst_splitter u_aw_split (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (cl_aw_valid_i[0]),
    .req_i       (cl_aw_i[0]),
    .meta_i      (meta_i),
    .req_ready_o (aw_req_ready),
    .ax_o        (sys_aw_o),
    .ax_valid_o  (sys_aw_valid_o),
    .ax_ready_i  (sys_aw_ready_i)
  );

  ldst_read_fanout u_read_fanout (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sys_r_i       (sys_r_i),
    .sys_r_valid_i (sys_r_valid_i),
    .sys_r_ready_o (sys_r_ready_o),
    .cl_r_o        (cl_r_o),
    .cl_r_valid_o  (r_valid),
    .cl_r_ready_i  (cl_r_ready_i)
  );

  ldst_write_gather u_write_gather (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cl_w_i        (cl_w_i),
    .cl_w_valid_i  (cl_w_valid_i),
    .cl_w_ready_o  (w_ready),
    .sys_w_o       (sys_w_o),
    .sys_w_valid_o (sys_w_valid_o),
    .sys_w_ready_i (sys_w_ready_i)
  );

  // Write responses follow cluster 0
  assign sys_b_ready_o = cl_b_ready_i[0];

  always_comb begin
    // Address requests come from cluster 0 only
    cl_ar_ready_o    = '0;
    cl_aw_ready_o    = '0;
    cl_ar_ready_o[0] = ar_req_ready;
    cl_aw_ready_o[0] = aw_req_ready;
    for (int i = 0; i < vldst_cfg_pkg::NrClusters; i++) begin
      cl_w_ready_o[i] = w_ready;
      cl_r_valid_o[i] = r_valid;
      cl_b_o[i]       = sys_b_i;
      cl_b_valid_o[i] = sys_b_valid_i;
    end
  end

endmodule

// ==== tb/global_ldst_assert.sv ====
/*
 * Protocol checks for the global load-store unit, bound to its top level.
 * Burst page bounds, fixed burst fields, back-pressure stability and
 * lockstep read valids.
 */
`timescale 1ns/1ns

module global_ldst_assert (
  input logic                                 clk_i,
  input logic                                 rst_ni,
  input vldst_axi_pkg::axi_ax_t               sys_ar_o,
  input logic                                 sys_ar_valid_o,
  input logic                                 sys_ar_ready_i,
  input vldst_axi_pkg::axi_ax_t               sys_aw_o,
  input logic                                 sys_aw_valid_o,
  input logic                                 sys_aw_ready_i,
  input vldst_axi_pkg::sys_w_t                sys_w_o,
  input logic                                 sys_w_valid_o,
  input logic                                 sys_w_ready_i,
  input logic [vldst_cfg_pkg::NrClusters-1:0] cl_r_valid_o,
  input logic [vldst_cfg_pkg::NrClusters-1:0] cl_ar_ready_o,
  input logic [vldst_cfg_pkg::NrClusters-1:0] cl_aw_ready_o
);

  int fail_cnt = 0;

  // Page of the last byte a burst touches
  function automatic logic [19:0] end_page(input vldst_axi_pkg::axi_ax_t ax);
    logic [31:0] last_byte;
    last_byte = ax.addr.flat + ((32'(ax.len) + 32'd1) << vldst_axi_pkg::AxiSize) - 32'd1;
    return last_byte[31:vldst_axi_pkg::PageOffsetBits];
  endfunction

  function automatic logic fixed_fields(input vldst_axi_pkg::axi_ax_t ax);
    return ax.size == 3'(vldst_axi_pkg::AxiSize) && ax.burst == vldst_axi_pkg::BurstIncr &&
           ax.cache == vldst_axi_pkg::CacheModifiable;
  endfunction

  ar_in_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sys_ar_valid_o |-> end_page(sys_ar_o) == sys_ar_o.addr.pg.page && fixed_fields(sys_ar_o))
  else begin
    $error("AR burst leaves its page or has wrong fixed fields");
    fail_cnt++;
  end

  aw_in_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sys_aw_valid_o |-> end_page(sys_aw_o) == sys_aw_o.addr.pg.page && fixed_fields(sys_aw_o))
  else begin
    $error("AW burst leaves its page or has wrong fixed fields");
    fail_cnt++;
  end

  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sys_ar_valid_o && !sys_ar_ready_i |=> sys_ar_valid_o && $stable(sys_ar_o))
  else begin
    $error("AR burst changed under back-pressure");
    fail_cnt++;
  end

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sys_aw_valid_o && !sys_aw_ready_i |=> sys_aw_valid_o && $stable(sys_aw_o))
  else begin
    $error("AW burst changed under back-pressure");
    fail_cnt++;
  end

  w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sys_w_valid_o && !sys_w_ready_i |=> sys_w_valid_o && $stable(sys_w_o))
  else begin
    $error("W beat changed under back-pressure");
    fail_cnt++;
  end

  // Busy splitters refuse requests, other clusters never get one in
  req_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(sys_aw_valid_o && cl_aw_ready_o[0]) && !(sys_ar_valid_o && cl_ar_ready_o[0]) &&
    cl_ar_ready_o[3:1] == '0 && cl_aw_ready_o[3:1] == '0)
  else begin
    $error("request ready while splitter busy or on another cluster");
    fail_cnt++;
  end

  r_lockstep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&cl_r_valid_o) == (|cl_r_valid_o))
  else begin
    $error("cluster read valids are not raised together");
    fail_cnt++;
  end

endmodule

// ==== tb/tb_global_ldst.sv ====
/*
 * Testbench for the global load-store unit. Issues unit-stride requests,
 * drives random read, write and response traffic, and checks every
 * handshake against a model of the burst, fan-out and gather rules.
 */
`timescale 1ns/1ns

module tb_global_ldst;

  logic                                                    clk_i;
  logic                                                    rst_ni;
  vldst_cfg_pkg::ldst_meta_t                               meta_i;
  vldst_axi_pkg::axi_ax_t [vldst_cfg_pkg::NrClusters-1:0]  cl_ar_i;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_ar_valid_i;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_ar_ready_o;
  vldst_axi_pkg::axi_ax_t [vldst_cfg_pkg::NrClusters-1:0]  cl_aw_i;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_aw_valid_i;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_aw_ready_o;
  vldst_axi_pkg::cl_w_t [vldst_cfg_pkg::NrClusters-1:0]    cl_w_i;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_w_valid_i;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_w_ready_o;
  vldst_axi_pkg::cl_r_t [vldst_cfg_pkg::NrClusters-1:0]    cl_r_o;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_r_valid_o;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_r_ready_i;
  vldst_axi_pkg::axi_b_t [vldst_cfg_pkg::NrClusters-1:0]   cl_b_o;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_b_valid_o;
  logic [vldst_cfg_pkg::NrClusters-1:0]                    cl_b_ready_i;
  vldst_axi_pkg::axi_ax_t                                  sys_ar_o;
  logic                                                    sys_ar_valid_o;
  logic                                                    sys_ar_ready_i;
  vldst_axi_pkg::axi_ax_t                                  sys_aw_o;
  logic                                                    sys_aw_valid_o;
  logic                                                    sys_aw_ready_i;
  vldst_axi_pkg::sys_w_t                                   sys_w_o;
  logic                                                    sys_w_valid_o;
  logic                                                    sys_w_ready_i;
  vldst_axi_pkg::sys_r_t                                   sys_r_i;
  logic                                                    sys_r_valid_i;
  logic                                                    sys_r_ready_o;
  vldst_axi_pkg::axi_b_t                                   sys_b_i;
  logic                                                    sys_b_valid_i;
  logic                                                    sys_b_ready_o;

  logic [31:0]           lfsr = 32'h93fcd054;
  // Expected bursts as {id, addr, len}
  logic [43:0]           exp_ar_q[$];
  logic [43:0]           exp_aw_q[$];
  vldst_axi_pkg::sys_r_t r_q[$];
  vldst_axi_pkg::sys_w_t w_q[$];
  int                    val_errs = 0;
  int                    tmo_errs = 0;
  int                    r_sent = 0;
  int                    w_caps = 0;
  logic                  traffic_on = 1'b0;

  global_ldst dut0 (.*);

  bind global_ldst global_ldst_assert u_assert (.*);

  always #2 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  // Burst rule applied to one request
  task automatic add_bursts(input bit is_aw, input logic [3:0] id, input logic [31:0] addr,
                            input vldst_cfg_pkg::ldst_meta_t m);
    logic [31:0] start;
    logic [31:0] stop;
    logic [31:0] lim;
    logic [31:0] covered;
    logic [31:0] rem;
    logic        last_burst;
    rem = 32'(m.vl);
    last_burst = 1'b0;
    while (!last_burst) begin
      start = addr & ~32'h1f;
      stop  = ((addr + (rem << m.vew) - 1) & ~32'h1f) + 32;
      lim   = (start & ~32'hfff) + 32'h1000;
      if (lim < stop) begin
        stop = lim;
      end
      lim = start + 32'(vldst_axi_pkg::MaxBurstBeats) * 32;
      if (lim < stop) begin
        stop = lim;
      end
      if (is_aw) begin
        exp_aw_q.push_back({id, start, 8'((stop - start) / 32 - 1)});
      end else begin
        exp_ar_q.push_back({id, start, 8'((stop - start) / 32 - 1)});
      end
      covered    = (stop - addr) >> m.vew;
      last_burst = rem <= covered;
      rem        = rem - covered;
      addr       = stop;
    end
  endtask

  task automatic wait_ready(input bit is_aw, input int limit);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!(is_aw ? cl_aw_ready_o[0] : cl_ar_ready_o[0]) && n < limit);
    if (!(is_aw ? cl_aw_ready_o[0] : cl_ar_ready_o[0])) begin
      tmo_errs++;
      $display("timeout: %s splitter never became ready", is_aw ? "AW" : "AR");
    end
    #1;
  endtask

  task automatic issue_req(input bit is_aw, input logic [31:0] addr,
                           input vldst_cfg_pkg::vl_t vl, input vldst_cfg_pkg::vew_e vew);
    vldst_axi_pkg::axi_ax_t ax;
    ax           = '0;
    ax.addr.flat = addr;
    ax.id        = 4'(rand_bits(4));
    meta_i       = {vl, vew};
    add_bursts(is_aw, ax.id, addr, meta_i);
    if (is_aw) begin
      cl_aw_i[0]       = ax;
      cl_aw_valid_i[0] = 1'b1;
    end else begin
      cl_ar_i[0]       = ax;
      cl_ar_valid_i[0] = 1'b1;
    end
    wait_ready(is_aw, 200);
    cl_aw_valid_i[0] = 1'b0;
    cl_ar_valid_i[0] = 1'b0;
    // Splitter returns to ready after its last burst
    wait_ready(is_aw, 5000);
  endtask

  task automatic check_burst(input bit is_aw, input vldst_axi_pkg::axi_ax_t ax);
    logic [43:0] exp;
    assert ((is_aw ? exp_aw_q.size() : exp_ar_q.size()) != 0) begin
      exp = is_aw ? exp_aw_q.pop_front() : exp_ar_q.pop_front();
      assert ({ax.id, ax.addr.flat, ax.len} == exp) else begin
        val_errs++;
        $display("error %s id/addr/len: got %h/%h/%h, expected %h/%h/%h",
                 is_aw ? "sys_aw_o" : "sys_ar_o", ax.id, ax.addr.flat, ax.len,
                 exp[43:40], exp[39:8], exp[7:0]);
      end
    end else begin
      val_errs++;
      $display("unexpected burst at address %h", ax.addr.flat);
    end
  endtask

  // Checks on every rising edge
  always @(posedge clk_i) begin
    vldst_axi_pkg::sys_r_t rb;
    vldst_axi_pkg::cl_r_t  er;
    vldst_axi_pkg::sys_w_t ew;
    logic                  w_rdy_exp;
    if (rst_ni) begin
      if (sys_ar_valid_o && sys_ar_ready_i) begin
        check_burst(1'b0, sys_ar_o);
      end
      if (sys_aw_valid_o && sys_aw_ready_i) begin
        check_burst(1'b1, sys_aw_o);
      end
      if (cl_r_valid_o[0] && (&cl_r_ready_i)) begin
        assert (r_q.size() != 0) begin
          rb = r_q.pop_front();
          for (int i = 0; i < vldst_cfg_pkg::NrClusters; i++) begin
            er.data = rb.data[i*vldst_cfg_pkg::ClusterDataWidth +: vldst_cfg_pkg::ClusterDataWidth];
            er.id   = rb.id;
            er.resp = rb.resp;
            er.last = rb.last;
            assert (cl_r_o[i] == er) else begin
              val_errs++;
              $display("error cl_r_o[%0d]: got %h, expected %h", i, cl_r_o[i], er);
            end
          end
        end else begin
          val_errs++;
          $display("clusters took a read beat that the system never sent");
        end
      end
      if (sys_r_valid_i && sys_r_ready_o) begin
        r_q.push_back(sys_r_i);
      end
      // Gather buffer is empty while no merged beat is outstanding
      w_rdy_exp = (&cl_w_valid_i) && (w_q.size() == 0);
      for (int i = 0; i < vldst_cfg_pkg::NrClusters; i++) begin
        assert (cl_w_valid_i[i] ? cl_w_ready_o[i] == w_rdy_exp
                                : !(cl_w_ready_o[i] && w_q.size() != 0)) else begin
          val_errs++;
          $display("error cl_w_ready_o[%0d]: got %h, expected %h",
                   i, cl_w_ready_o[i], w_rdy_exp);
        end
      end
      if (sys_w_valid_o && sys_w_ready_i) begin
        assert (w_q.size() != 0) begin
          ew = w_q.pop_front();
          assert (sys_w_o == ew) else begin
            val_errs++;
            $display("error sys_w_o: got %h, expected %h", sys_w_o, ew);
          end
        end else begin
          val_errs++;
          $display("system write beat without gathered cluster beats");
        end
      end
      if (w_rdy_exp) begin
        for (int i = 0; i < vldst_cfg_pkg::NrClusters; i++) begin
          ew.data[i*64 +: 64] = cl_w_i[i].data;
          ew.strb[i*8 +: 8]   = cl_w_i[i].strb;
        end
        ew.last = cl_w_i[0].last;
        w_q.push_back(ew);
        w_caps++;
      end
      for (int i = 0; i < vldst_cfg_pkg::NrClusters; i++) begin
        assert (cl_b_valid_o[i] == sys_b_valid_i && cl_b_o[i] == sys_b_i) else begin
          val_errs++;
          $display("error cl_b_o[%0d]: got %h valid %h, expected %h valid %h",
                   i, cl_b_o[i], cl_b_valid_o[i], sys_b_i, sys_b_valid_i);
        end
      end
      assert (sys_b_ready_o == cl_b_ready_i[0]) else begin
        val_errs++;
        $display("error sys_b_ready_o: got %h, expected %h", sys_b_ready_o, cl_b_ready_i[0]);
      end
    end
  end

  // Memory side and cluster data traffic
  always @(posedge clk_i) begin
    logic                                 r_fire;
    logic                                 b_fire;
    logic [vldst_cfg_pkg::NrClusters-1:0] w_fire;
    r_fire = sys_r_valid_i & sys_r_ready_o;
    b_fire = sys_b_valid_i & sys_b_ready_o;
    w_fire = cl_w_valid_i & cl_w_ready_o;
    #1;
    if (traffic_on) begin
      sys_ar_ready_i = 1'(rand_bits(1));
      sys_aw_ready_i = 1'(rand_bits(1));
      sys_w_ready_i  = 1'(rand_bits(1));
      // A response is held until the system sees it taken
      if (!sys_b_valid_i || b_fire) begin
        sys_b_valid_i = 1'(rand_bits(1));
        sys_b_i       = 6'(rand_bits(6));
      end
      cl_b_ready_i   = 4'(rand_bits(4));
      for (int i = 0; i < vldst_cfg_pkg::NrClusters; i++) begin
        cl_r_ready_i[i] = |rand_bits(2);
        if (!cl_w_valid_i[i] || w_fire[i]) begin
          cl_w_valid_i[i] = w_caps < 40 && 1'(rand_bits(1));
          cl_w_i[i]       = {rand_bits(64), 8'(rand_bits(8)), 1'(rand_bits(1))};
        end
      end
      if (!sys_r_valid_i || r_fire) begin
        sys_r_valid_i = r_sent < 40 && 1'(rand_bits(1));
        sys_r_i = {rand_bits(64), rand_bits(64), rand_bits(64), rand_bits(64), 7'(rand_bits(7))};
        if (sys_r_valid_i) begin
          r_sent++;
        end
      end
    end
  end

  initial begin
    int n;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    meta_i         = '0;
    cl_ar_i        = '0;
    cl_ar_valid_i  = '0;
    cl_aw_i        = '0;
    cl_aw_valid_i  = '0;
    cl_w_i         = '0;
    cl_w_valid_i   = '0;
    cl_r_ready_i   = '0;
    cl_b_ready_i   = '0;
    sys_ar_ready_i = 1'b0;
    sys_aw_ready_i = 1'b0;
    sys_w_ready_i  = 1'b0;
    sys_r_i        = '0;
    sys_r_valid_i  = 1'b0;
    sys_b_i        = '0;
    sys_b_valid_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(posedge clk_i);
    assert (!sys_ar_valid_o && !sys_aw_valid_o && !sys_w_valid_o && cl_r_valid_o == '0 &&
            cl_b_valid_o == '0 && cl_ar_ready_o[0] && cl_aw_ready_o[0]) else begin
      val_errs++;
      $display("outputs are not idle after reset");
    end
    @(negedge clk_i);
    traffic_on = 1'b1;
    @(posedge clk_i);
    #1;
    // Page crossing, then a request of about 500 beats
    issue_req(1'b0, 32'h0000_0ff0, 16'd64, vldst_cfg_pkg::EW32);
    issue_req(1'b0, 32'h0000_2004, 16'd2000, vldst_cfg_pkg::EW64);
    issue_req(1'b1, 32'h0000_1fe8, 16'd40, vldst_cfg_pkg::EW16);
    issue_req(1'b1, 32'h0003_0010, 16'd1500, vldst_cfg_pkg::EW64);
    for (int k = 0; k < 12; k++) begin
      issue_req(k[0], 32'(rand_bits(20)), 16'(rand_bits(10)) + 16'd1,
                vldst_cfg_pkg::vew_e'(2'(rand_bits(2))));
    end
    n = 0;
    while ((w_caps < 40 || r_sent < 40 || sys_r_valid_i || r_q.size() != 0 ||
            w_q.size() != 0) && n < 3000) begin
      @(posedge clk_i);
      n++;
    end
    if (n >= 3000) begin
      tmo_errs++;
      $display("timeout: read or write data traffic did not drain");
    end
    assert (exp_ar_q.size() == 0 && exp_aw_q.size() == 0) else begin
      val_errs++;
      $display("expected bursts never appeared on the system address channels");
    end
    $display("errors: value %0d, timeout %0d, assertion %0d",
             val_errs, tmo_errs, dut0.u_assert.fail_cnt);
    if (val_errs + tmo_errs + dut0.u_assert.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== cluster_ldst.f ====
hw/vldst_cfg_pkg.sv
hw/vldst_axi_pkg.sv
hw/ldst_burst_calc.sv
hw/ldst_burst_splitter.sv
hw/ldst_read_fanout.sv
hw/ldst_write_gather.sv
hw/global_ldst.sv
tb/global_ldst_assert.sv
tb/tb_global_ldst.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_global_ldst -f cluster_ldst.f

# Assertion failures are counted by the testbench, so the run continues past them.
# The exit status is that of grep, which looks for the pass line.
./obj_dir/Vtb_global_ldst +verilator+error+limit+1000 \
  | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null
